//--- all.f
+incdir+include
verilog/wfd_pkg.sv
verilog/wfd_trigger_manager.sv
verilog/wfd_fill_fifo.sv
verilog/wfd_rx_arbiter.sv
verilog/wfd_tx_router.sv
verilog/wfd_readout_sequencer.sv
verilog/wfd_top.sv
bench/wfd_channel_model.sv
bench/wfd_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the WFD readout testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module wfd_tb \
    -f all.f -o wfd_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/wfd_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Test OK" sim.log; then
    echo "no result line in sim.log"
    exit 1
fi
exit 0

//--- bench/wfd_tb.sv
// WFD readout testbench

`timescale 1ns/1ps
`default_nettype none

`include "wfd_settings.svh"

module wfd_tb;
    import wfd_pkg::*;

    localparam int NUM_FILLS = 20;
    localparam int TIMEOUT   = NUM_FILLS * 200;    // cycles

    logic                      clk125 = 1'b0;
    logic                      arst_n = 1'b0;
    logic                      trigger = 1'b0;
    trig_mask_t                chan_done = '0;
    trig_mask_t                acq_trigs;
    logic [`WFD_NUM_CHAN-1:0]  tx_valid;
    chan_beat_t                tx_beat [`WFD_NUM_CHAN];
    wire [`WFD_NUM_CHAN-1:0]   tx_ready;
    wire [`WFD_NUM_CHAN-1:0]   rx_valid;
    wire chan_beat_t           rx_beat [`WFD_NUM_CHAN];
    logic [`WFD_NUM_CHAN-1:0]  rx_ready;
    logic                      daq_valid, daq_header, daq_trailer;
    daq_word_t                 daq_data;
    logic                      daq_ready = 1'b0;

    integer     seed = 32'h00d9e89d;
    integer     errors = 0;
    int         cycles = 0;
    int         pulses = 0;
    int         fills_done = 0;
    int         done_cnt [`WFD_NUM_TRIG];   // cycles until each done pulse
    int         pending;                    // done pulses still to come
    int         release_cnt = 0;            // edges until the fill is stored
    int         word_idx = -1;              // -1 while a header is due
    fill_num_t  exp_fill = 1;
    logic       exp_pulse = 1'b0;           // acq pulse due after the next edge
    logic       waiting = 1'b0;             // trigger manager busy with a fill
    logic       rd_busy = 1'b0;             // a fill is being read out
    logic       timed_out = 1'b0;
    logic       held = 1'b0;
    daq_word_t  held_data;
    logic       held_hdr, held_trl;

    always #50 clk125 = ~clk125;

    wfd_top u_wfd_top (
        .clk125(clk125), .arst_n(arst_n), .trigger(trigger),
        .acq_trigs(acq_trigs), .chan_done(chan_done),
        .tx_valid(tx_valid), .tx_beat(tx_beat), .tx_ready(tx_ready),
        .rx_valid(rx_valid), .rx_beat(rx_beat), .rx_ready(rx_ready),
        .daq_valid(daq_valid), .daq_header(daq_header), .daq_trailer(daq_trailer),
        .daq_data(daq_data), .daq_ready(daq_ready)
    );

    for (genvar c = 0; c < `WFD_NUM_CHAN; c++) begin : g_link
        wfd_channel_model #(.CHAN(c), .SEED(32'h00d9e89d + c + 1)) u_chan (
            .clk125(clk125), .arst_n(arst_n),
            .tx_valid(tx_valid[c]), .tx_beat(tx_beat[c]), .tx_ready(tx_ready[c]),
            .rx_valid(rx_valid[c]), .rx_beat(rx_beat[c]), .rx_ready(rx_ready[c])
        );
    end

    // next DAQ word of the fill in progress
    task check_daq_word;
        int        n;
        daq_word_t exp;
        logic      eh, et;
        begin
            n   = (exp_fill % 4) + 1;
            exp = '0;
            eh  = 1'b0;
            et  = 1'b0;
            if (word_idx < 0) begin
                exp[63:56] = `WFD_DAQ_HEADER_TAG;
                exp[`WFD_FILL_WIDTH-1:0] = exp_fill;
                eh = 1'b1;
            end else if (word_idx < 2 * n) begin
                // channel 0 first, then channel 1
                exp[32]   = 1'(word_idx / n);
                exp[31:0] = {exp_fill, 4'(word_idx / n), 4'(word_idx % n)};
            end else begin
                exp[63:56] = `WFD_DAQ_TRAILER_TAG;
                exp[47:32] = 16'(2 * n);
                exp[`WFD_FILL_WIDTH-1:0] = exp_fill;
                et = 1'b1;
            end
            a_daq_word: assert (daq_data == exp && daq_header == eh && daq_trailer == et)
            else begin
                errors++;
                $display("Fail daq_data %h header %h trailer %h, expected %h %h %h",
                         daq_data, daq_header, daq_trailer, exp, eh, et);
            end
            if (et) begin
                word_idx = -1;
                fills_done++;
                exp_fill = exp_fill + 1'b1;
            end else begin
                word_idx++;
            end
        end
    endtask

    always @(negedge clk125) begin
        if (arst_n) begin
            cycles++;
            a_acq: assert (acq_trigs == (exp_pulse ? '1 : '0)) else begin
                errors++;
                $display("Fail acq_trigs %h, expected %h", acq_trigs,
                         exp_pulse ? {`WFD_NUM_TRIG{1'b1}} : {`WFD_NUM_TRIG{1'b0}});
            end
            if (held) begin   // stalled DAQ word must not move
                a_hold: assert (daq_data == held_data && daq_header == held_hdr &&
                                daq_trailer == held_trl) else begin
                    errors++;
                    $display("Fail daq_data %h header %h trailer %h under stall, held %h %h %h",
                             daq_data, daq_header, daq_trailer, held_data, held_hdr, held_trl);
                end
            end
            if (exp_pulse) begin
                waiting = 1'b1;
                pulses++;
                for (int i = 0; i < `WFD_NUM_TRIG; i++) done_cnt[i] = 1 + {$random(seed)} % 8;
            end
            if (release_cnt > 0) begin
                release_cnt--;
                if (release_cnt == 0) waiting = 1'b0;  // trigger manager idle again
            end
            pending = 0;
            for (int i = 0; i < `WFD_NUM_TRIG; i++) begin
                chan_done[i] = (done_cnt[i] == 1);
                if (done_cnt[i] > 0) done_cnt[i]--;
                if (done_cnt[i] > 0) pending++;
            end
            // last done goes out now: mask full, fill offered, fill stored
            if (|chan_done && pending == 0) release_cnt = 3;
            trigger   = (pulses < NUM_FILLS) && ({$random(seed)} % 6 == 0);
            daq_ready = ({$random(seed)} % 3 != 0);
            #1;
            if (daq_valid && daq_header) rd_busy = 1'b1;  // sequencer has left idle
            // at most one fill waits in the FIFO, so it always has room
            exp_pulse = trigger && !waiting && !rd_busy;
            held      = daq_valid && !daq_ready;
            held_data = daq_data;
            held_hdr  = daq_header;
            held_trl  = daq_trailer;
            if (daq_valid && daq_ready) begin
                if (daq_trailer) rd_busy = 1'b0;   // idle after this edge
                check_daq_word();
            end
        end
    end

    initial begin
        for (int i = 0; i < `WFD_NUM_TRIG; i++) done_cnt[i] = 0;
        repeat (4) @(posedge clk125);
        @(negedge clk125);
        arst_n <= 1'b1;
        while (!(fills_done == NUM_FILLS && pulses == NUM_FILLS) && cycles < TIMEOUT)
            @(posedge clk125);
        timed_out = (cycles >= TIMEOUT);
        repeat (20) @(posedge clk125);    // catch any stray pulse or word
        if (timed_out) begin
            errors++;
            $display("timeout: readout did not finish within %0d cycles", TIMEOUT);
        end
        a_counts: assert (fills_done == pulses) else begin
            errors++;
            $display("Fail fills read out %h, acq pulses %h", fills_done, pulses);
        end
        errors = errors + g_link[0].u_chan.errors + g_link[1].u_chan.errors;
        $display("fills %0d, acq pulses %0d, errors %0d", fills_done, pulses, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/wfd_channel_model.sv
// Channel FPGA model

`timescale 1ns/1ps
`default_nettype none

`include "wfd_settings.svh"

module wfd_channel_model #(
    parameter int CHAN = 0,
    parameter int SEED = 0
) (
    input  wire logic                clk125,
    input  wire logic                arst_n,
    input  wire logic                tx_valid,      // request from the master
    input  wire wfd_pkg::chan_beat_t tx_beat,
    output logic                     tx_ready = 1'b0,
    output logic                     rx_valid = 1'b0,   // response to the master
    output wfd_pkg::chan_beat_t      rx_beat = '0,
    input  wire logic                rx_ready
);
    import wfd_pkg::*;

    integer     seed = SEED;
    integer     errors = 0;
    fill_num_t  exp_fill = 1;   // next request should carry this fill
    fill_num_t  cur_fill;       // fill being answered
    chan_beat_t req_s;          // request beat seen before the edge
    int         n_words;
    int         k;              // index of the word on offer
    logic       req_seen = 1'b0;
    logic       beat_taken = 1'b0;
    logic       active = 1'b0;

    always @(negedge clk125) begin
        if (!arst_n) begin
            tx_ready   = 1'b0;
            rx_valid   = 1'b0;
            active     = 1'b0;
            req_seen   = 1'b0;
            beat_taken = 1'b0;
        end else begin
            if (req_seen) begin
                a_req: assert (req_s.dest == chan_id_t'(CHAN) && req_s.last &&
                               req_s.data == chan_word_t'(exp_fill)) else begin
                    errors++;
                    $display("Fail ch%0d request dest %h data %h, expected %h %h",
                             CHAN, req_s.dest, req_s.data, CHAN, exp_fill);
                end
                cur_fill = req_s.data[`WFD_FILL_WIDTH-1:0];
                n_words  = (cur_fill % 4) + 1;
                k        = 0;
                active   = 1'b1;
                exp_fill = exp_fill + 1'b1;
            end
            if (beat_taken) begin
                rx_valid = 1'b0;
                k++;
                if (k == n_words) active = 1'b0;   // packet sent
            end
            // next word, with a random gap now and then
            if (active && !rx_valid && ({$random(seed)} % 4 != 0)) begin
                rx_valid     = 1'b1;
                rx_beat.data = {cur_fill, 4'(CHAN), 4'(k)};
                rx_beat.last = (k == n_words - 1);
                rx_beat.dest = chan_id_t'(CHAN);
            end
            tx_ready = ({$random(seed)} % 3 != 0);     // link back-pressure
            #1;
            // handshakes that the coming edge will complete
            req_seen   = tx_valid && tx_ready;
            req_s      = tx_beat;
            beat_taken = rx_valid && rx_ready;
        end
    end

endmodule

`default_nettype wire

//--- verilog/wfd_top.sv
// WFD master FPGA readout top

`timescale 1ns/1ps
`default_nettype none

`include "wfd_settings.svh"

module wfd_top (
    input  wire logic                     clk125,
    input  wire logic                     arst_n,
    input  wire logic                     trigger,
    output wfd_pkg::trig_mask_t           acq_trigs,    // go to channel FPGAs
    input  wire wfd_pkg::trig_mask_t      chan_done,
    // request streams to the channel links
    output logic [`WFD_NUM_CHAN-1:0]      tx_valid,
    output wfd_pkg::chan_beat_t           tx_beat [`WFD_NUM_CHAN],
    input  wire logic [`WFD_NUM_CHAN-1:0] tx_ready,
    // response streams from the channel links
    input  wire logic [`WFD_NUM_CHAN-1:0] rx_valid,
    input  wire wfd_pkg::chan_beat_t      rx_beat [`WFD_NUM_CHAN],
    output logic [`WFD_NUM_CHAN-1:0]      rx_ready,
    // AMC13 DAQ link
    output logic                          daq_valid,
    output logic                          daq_header,
    output logic                          daq_trailer,
    output wfd_pkg::daq_word_t            daq_data,
    input  wire logic                     daq_ready
);
    import wfd_pkg::*;

    logic       fill_valid, fill_ready;     // tm to fill FIFO
    fill_num_t  fill_num;
    logic       fifo_valid, fifo_pop;       // fill FIFO to cm
    fill_num_t  fifo_num;
    logic       req_valid, req_ready;       // cm to tx switch
    chan_beat_t req_beat;
    logic       resp_valid, resp_ready;     // rx switch to cm
    chan_beat_t resp_beat;
    logic       cm_busy;

    wfd_trigger_manager tm (
        .clk125(clk125), .arst_n(arst_n),
        .trigger(trigger), .busy(cm_busy), .chan_done(chan_done),
        .fill_ready(fill_ready), .acq_trigs(acq_trigs),
        .fill_valid(fill_valid), .fill_num(fill_num)
    );

    wfd_fill_fifo fill_num_fifo (
        .clk125(clk125), .arst_n(arst_n),
        .wr_valid(fill_valid), .wr_num(fill_num), .rd_pop(fifo_pop),
        .wr_ready(fill_ready), .rd_valid(fifo_valid), .rd_num(fifo_num)
    );

    wfd_rx_arbiter rx_switch (
        .clk125(clk125), .arst_n(arst_n),
        .rx_valid(rx_valid), .rx_beat(rx_beat), .out_ready(resp_ready),
        .rx_ready(rx_ready), .out_valid(resp_valid), .out_beat(resp_beat)
    );

    wfd_tx_router tx_switch (
        .req_valid(req_valid), .req_beat(req_beat), .tx_ready(tx_ready),
        .req_ready(req_ready), .tx_valid(tx_valid), .tx_beat(tx_beat)
    );

    // readout side of the command manager
    wfd_readout_sequencer cm (
        .clk125(clk125), .arst_n(arst_n),
        .fifo_valid(fifo_valid), .fifo_num(fifo_num), .fifo_pop(fifo_pop),
        .req_ready(req_ready), .req_valid(req_valid), .req_beat(req_beat),
        .resp_valid(resp_valid), .resp_beat(resp_beat), .resp_ready(resp_ready),
        .daq_ready(daq_ready), .daq_valid(daq_valid), .daq_header(daq_header),
        .daq_trailer(daq_trailer), .daq_data(daq_data), .busy(cm_busy)
    );

endmodule

`default_nettype wire

//--- verilog/wfd_readout_sequencer.sv
// Readout sequencer

`timescale 1ns/1ps
`default_nettype none

`include "wfd_settings.svh"

module wfd_readout_sequencer (
    input  wire logic                clk125,
    input  wire logic                arst_n,
    input  wire logic                fifo_valid,
    input  wire wfd_pkg::fill_num_t  fifo_num,
    input  wire logic                req_ready,
    input  wire logic                resp_valid,
    input  wire wfd_pkg::chan_beat_t resp_beat,
    input  wire logic                daq_ready,
    output logic                     fifo_pop,
    output logic                     req_valid,
    output wfd_pkg::chan_beat_t      req_beat,
    output logic                     resp_ready,
    output logic                     daq_valid,
    output logic                     daq_header,
    output logic                     daq_trailer,
    output wfd_pkg::daq_word_t       daq_data,
    output logic                     busy
);
    import wfd_pkg::*;

    seq_state_t  state;
    fill_num_t   fill;          // fill being read out
    chan_id_t    chan;          // channel currently requested
    logic [15:0] word_cnt;      // data words sent this fill
    logic        hdr_load;
    logic        dat_load;
    logic        trl_load;
    daq_word_t   hdr_word;
    daq_word_t   dat_word;
    daq_word_t   trl_word;

    assign busy       = (state != seq_idle);
    assign hdr_load   = (state == seq_idle) && fifo_valid;
    assign fifo_pop   = hdr_load;
    assign resp_ready = (state == seq_collect) && (!daq_valid || daq_ready);
    assign dat_load   = resp_valid && resp_ready;
    assign trl_load   = (state == seq_trailer) && !daq_trailer && (!daq_valid || daq_ready);

    // request carries just the fill number
    always_comb begin
        req_beat.data = chan_word_t'(fill);
        req_beat.last = 1'b1;
        req_beat.dest = chan;
    end

    always_comb begin
        hdr_word = '0;
        hdr_word[63:56] = `WFD_DAQ_HEADER_TAG;
        hdr_word[`WFD_FILL_WIDTH-1:0] = fifo_num;
        dat_word = daq_word_t'({resp_beat.dest, resp_beat.data});    // source id at bit 32
        trl_word = '0;
        trl_word[63:56] = `WFD_DAQ_TRAILER_TAG;
        trl_word[47:32] = word_cnt;
        trl_word[`WFD_FILL_WIDTH-1:0] = fill;
    end

    always_ff @(posedge clk125) begin
        if (hdr_load) fill <= fifo_num;
        if (hdr_load)      daq_data <= hdr_word;
        else if (dat_load) daq_data <= dat_word;
        else if (trl_load) daq_data <= trl_word;
    end

    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            state       <= seq_idle;
            chan        <= '0;
            word_cnt    <= '0;
            req_valid   <= 1'b0;
            daq_valid   <= 1'b0;
            daq_header  <= 1'b0;
            daq_trailer <= 1'b0;
        end else begin
            if (daq_valid && daq_ready) begin   // current DAQ word taken
                daq_valid   <= 1'b0;
                daq_header  <= 1'b0;
                daq_trailer <= 1'b0;
            end
            case (state)
                seq_idle: if (hdr_load) begin
                    chan       <= '0;
                    word_cnt   <= '0;
                    daq_valid  <= 1'b1;
                    daq_header <= 1'b1;
                    state      <= seq_header;
                end
                seq_header: if (daq_ready) begin
                    req_valid <= 1'b1;
                    state     <= seq_request;
                end
                seq_request: if (req_ready) begin
                    req_valid <= 1'b0;
                    state     <= seq_collect;
                end
                seq_collect: if (dat_load) begin
                    daq_valid <= 1'b1;
                    word_cnt  <= word_cnt + 1'b1;
                    if (resp_beat.last) begin
                        if (chan == chan_id_t'(`WFD_NUM_CHAN - 1)) begin
                            state <= seq_trailer;
                        end else begin
                            chan      <= chan + 1'b1;   // on to the next link
                            req_valid <= 1'b1;
                            state     <= seq_request;
                        end
                    end
                end
                seq_trailer: begin
                    if (trl_load) begin
                        daq_valid   <= 1'b1;
                        daq_trailer <= 1'b1;
                    end else if (daq_trailer && daq_ready) begin
                        state <= seq_idle;  // fill complete
                    end
                end
                default: state <= seq_idle;
            endcase
        end
    end

    a_daq_hold: assert property (@(posedge clk125) disable iff (!arst_n)
        daq_valid && !daq_ready |=> $stable(daq_data));

endmodule

`default_nettype wire

//--- verilog/wfd_tx_router.sv
// Channel transmit router

`timescale 1ns/1ps
`default_nettype none

`include "wfd_settings.svh"

module wfd_tx_router (
    input  wire logic                  req_valid,
    input  wire wfd_pkg::chan_beat_t   req_beat,
    input  wire logic [`WFD_NUM_CHAN-1:0] tx_ready,
    output logic                       req_ready,
    output logic [`WFD_NUM_CHAN-1:0]   tx_valid,
    output wfd_pkg::chan_beat_t        tx_beat [`WFD_NUM_CHAN]
);
    import wfd_pkg::*;

    // every link sees the beat, only the addressed one sees valid
    for (genvar c = 0; c < `WFD_NUM_CHAN; c++) begin : g_chan
        assign tx_valid[c] = req_valid && (req_beat.dest == chan_id_t'(c));
        assign tx_beat[c]  = req_beat;
    end

    assign req_ready = tx_ready[req_beat.dest];  // back-pressure from target link only

endmodule

`default_nettype wire

//--- verilog/wfd_rx_arbiter.sv
// Channel receive arbiter

`timescale 1ns/1ps
`default_nettype none

`include "wfd_settings.svh"

module wfd_rx_arbiter (
    input  wire logic                  clk125,
    input  wire logic                  arst_n,
    input  wire logic [`WFD_NUM_CHAN-1:0] rx_valid,
    input  wire wfd_pkg::chan_beat_t   rx_beat [`WFD_NUM_CHAN],
    input  wire logic                  out_ready,
    output logic [`WFD_NUM_CHAN-1:0]   rx_ready,
    output logic                       out_valid,
    output wfd_pkg::chan_beat_t        out_beat   // dest holds the source channel
);
    import wfd_pkg::*;

    chan_id_t grant;
    chan_id_t last_grant;   // round-robin pointer
    chan_id_t pick;
    logic     locked;       // grant held until end of packet
    logic     pkt_end;

    // first requester after the last-granted channel
    always_comb begin
        pick = last_grant;
        for (int i = `WFD_NUM_CHAN; i >= 1; i--) begin
            if (rx_valid[(int'(last_grant) + i) % `WFD_NUM_CHAN])
                pick = chan_id_t'((int'(last_grant) + i) % `WFD_NUM_CHAN);
        end
    end

    // beats pass straight through while locked
    always_comb begin
        rx_ready        = '0;
        rx_ready[grant] = locked && out_ready;
        out_valid       = locked && rx_valid[grant];
        out_beat        = rx_beat[grant];
        out_beat.dest   = grant;    // tag with source
    end

    assign pkt_end = out_valid && out_ready && out_beat.last;

    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            locked     <= 1'b0;
            grant      <= '0;
            last_grant <= chan_id_t'(`WFD_NUM_CHAN - 1);    // channel 0 goes first
        end else if (!locked) begin
            if (|rx_valid) begin
                locked <= 1'b1;
                grant  <= pick;
            end
        end else if (pkt_end) begin
            locked     <= 1'b0;
            last_grant <= grant;
        end
    end

    // new grant lands on a requester, and skips the last one when both wait
    a_grant_pick: assert property (@(posedge clk125) disable iff (!arst_n)
        !locked && |rx_valid |=> rx_valid[grant] &&
            (grant != last_grant || !$past(&rx_valid)));

endmodule

`default_nettype wire

//--- verilog/wfd_fill_fifo.sv
// Fill number FIFO

`timescale 1ns/1ps
`default_nettype none

`include "wfd_settings.svh"

module wfd_fill_fifo (
    input  wire logic               clk125,
    input  wire logic               arst_n,
    input  wire logic               wr_valid,
    input  wire wfd_pkg::fill_num_t wr_num,
    input  wire logic               rd_pop,
    output logic                    wr_ready,
    output logic                    rd_valid,
    output wfd_pkg::fill_num_t      rd_num
);
    import wfd_pkg::*;

    localparam int DEPTH = `WFD_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    fill_num_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;    // occupancy
    logic             push;
    logic             pop;

    assign wr_ready = (count != CNT_W'(DEPTH));    // low when full
    assign rd_valid = (count != '0);
    assign rd_num   = mem[rd_ptr];
    assign push     = wr_valid && wr_ready;
    assign pop      = rd_pop && rd_valid;

    always_ff @(posedge clk125) begin
        if (push) mem[wr_ptr] <= wr_num;
    end

    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)      count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
        end
    end

    // sequencer must only pop a fill it has seen
    a_no_empty_pop: assert property (@(posedge clk125) disable iff (!arst_n)
        rd_pop |-> rd_valid);

endmodule

`default_nettype wire

//--- verilog/wfd_trigger_manager.sv
// Trigger manager

`timescale 1ns/1ps
`default_nettype none

`include "wfd_settings.svh"

module wfd_trigger_manager (
    input  wire logic               clk125,
    input  wire logic               arst_n,
    input  wire logic               trigger,    // level, sampled every clock
    input  wire logic               busy,       // readout in progress
    input  wire wfd_pkg::trig_mask_t chan_done, // one-cycle done pulses
    input  wire logic               fill_ready,
    output wfd_pkg::trig_mask_t     acq_trigs,
    output logic                    fill_valid,
    output wfd_pkg::fill_num_t      fill_num
);
    import wfd_pkg::*;

    tm_state_t  state;
    trig_mask_t done_mask;  // sticky per-channel done

    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            state      <= tm_idle;
            acq_trigs  <= '0;
            done_mask  <= '0;
            fill_valid <= 1'b0;
            fill_num   <= fill_num_t'(1);   // first fill is 1
        end else begin
            case (state)
                tm_idle: begin
                    // only accept when the readout side can take another fill
                    if (trigger && !busy && fill_ready) begin
                        acq_trigs <= '1;
                        done_mask <= '0;
                        state     <= tm_wait_done;
                    end
                end
                tm_wait_done: begin
                    acq_trigs <= '0;    // single-cycle fan-out
                    if (&done_mask) begin
                        fill_valid <= 1'b1;
                        state      <= tm_store;
                    end else begin
                        done_mask <= done_mask | chan_done;
                    end
                end
                tm_store: begin
                    if (fill_ready) begin   // FIFO took it
                        fill_valid <= 1'b0;
                        fill_num   <= fill_num + 1'b1;
                        state      <= tm_idle;
                    end
                end
                default: state <= tm_idle;
            endcase
        end
    end

    // channels see a single go pulse per accepted trigger
    a_trig_single: assert property (@(posedge clk125) disable iff (!arst_n)
        |acq_trigs |=> !(|acq_trigs));

endmodule

`default_nettype wire

//--- verilog/wfd_pkg.sv
// WFD readout types

`default_nettype none

`include "wfd_settings.svh"

package wfd_pkg;

    typedef logic [`WFD_FILL_WIDTH-1:0] fill_num_t;     // incrementing fill number
    typedef logic [`WFD_CHAN_WIDTH-1:0] chan_word_t;    // channel stream payload
    typedef logic [$clog2(`WFD_NUM_CHAN)-1:0] chan_id_t;
    typedef logic [`WFD_NUM_TRIG-1:0] trig_mask_t;      // one bit per channel FPGA
    typedef logic [`WFD_DAQ_WIDTH-1:0] daq_word_t;

    // one beat of a channel stream
    // dest names the target on tx and the source on rx
    typedef struct packed {
        chan_word_t data;
        logic       last;   // final beat of a packet
        chan_id_t   dest;
    } chan_beat_t;

    // trigger manager
    typedef enum logic [1:0] {
        tm_idle,
        tm_wait_done,       // collecting channel done flags
        tm_store            // offering the fill number to the FIFO
    } tm_state_t;

    // readout sequencer
    typedef enum logic [2:0] {
        seq_idle,
        seq_request,        // one-word request to the current channel
        seq_collect,        // draining that channel's response packet
        seq_trailer,
        seq_header
    } seq_state_t;

endpackage

`default_nettype wire

//--- include/wfd_settings.svh
// WFD master readout settings

`ifndef WFD_SETTINGS_SVH
`define WFD_SETTINGS_SVH

// trigger fan-out and channel links
`define WFD_NUM_TRIG 5          // channel FPGAs receiving acq triggers
`define WFD_NUM_CHAN 2          // serial links with a readout path

// datapath widths
`define WFD_FILL_WIDTH 24       // fill number
`define WFD_CHAN_WIDTH 32       // one word on a channel stream
`define WFD_DAQ_WIDTH 64        // one AMC13 DAQ word

`define WFD_FIFO_DEPTH 4        // pending fill numbers

// top byte of the DAQ framing words
`define WFD_DAQ_HEADER_TAG 8'hA5
`define WFD_DAQ_TRAILER_TAG 8'h5A

`endif
